// File: Makefile
# Verilator build and run for the exec_unit testbench

VERILATOR ?= verilator
TOP       ?= tb_exec_unit
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= >>> PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulator output is searched for the pass line
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)' || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJ_DIR)

// File: project.f
verilog/rv32_pkg.sv
verilog/multiplier.sv
verilog/divider.sv
verilog/alu.sv
verilog/exec_unit.sv
sim/tb_exec_unit.sv

// File: sim/tb_exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_unit;
	import rv32_pkg::*;

	localparam logic [31:0] SEED           = 32'd58;
	localparam int          N_TESTS        = 600;
	localparam int          TIMEOUT_CYCLES = N_TESTS * 40;
	localparam int          MUL_LATENCY    = 2;
	localparam int          DIV_LATENCY    = 34;

	logic        clk;
	logic        rst_n;
	instr_t      instr;
	data_t       rs1_data;
	data_t       rs2_data;
	data_t       pc;
	data_t       result;
	logic        rd_wr;
	logic        mul_valid;
	logic        div_valid;
	logic [31:0] rng_state;
	int          cycle_count = 0;
	int          n_checks = 0;
	int          value_errors = 0;
	int          other_errors = 0;

	exec_unit u_exec_unit (
		.clk       (clk),
		.rst_n     (rst_n),
		.instr     (instr),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.pc        (pc),
		.result    (result),
		.rd_wr     (rd_wr),
		.mul_valid (mul_valid),
		.div_valid (div_valid)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] rand32(); // xorshift32
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// edge values show up about a third of the time
	function automatic data_t pick_operand();
		logic [31:0] r;
		r = rand32();
		case (r[3:0])
			4'd0:    return 32'h0000_0000;
			4'd1:    return 32'h8000_0000;
			4'd2:    return 32'hFFFF_FFFF;
			4'd3:    return 32'h7FFF_FFFF;
			4'd4:    return 32'h0000_0001;
			default: return rand32();
		endcase
	endfunction

	function automatic instr_t m_instr(logic [2:0] f3);
		instr_t ins;
		ins = instr_t'(rand32());
		ins.funct7 = M_INSTR;
		ins.funct3 = f3;
		ins.opcode = R;
		return ins;
	endfunction

	function automatic data_t base_model(instr_t ins, data_t a, data_t rs2);
		data_t      b;
		logic [4:0] sh;
		data_t      res;
		b  = (ins.opcode == I) ? get_imm(ins) : rs2;
		sh = (ins.opcode == I) ? ins.rs2 : rs2[4:0];
		case (ins.funct3)
			ADD:     res = (ins.opcode == R && ins[30]) ? a - b : a + b;
			SLL:     res = a << sh;
			SLT:     res = {31'b0, $signed(a) < $signed(b)};
			SLTU:    res = {31'b0, a < b};
			XOR:     res = a ^ b;
			SRL:     res = ins[30] ? data_t'($signed(a) >>> sh) : a >> sh;
			OR:      res = a | b;
			default: res = a & b;
		endcase
		return res;
	endfunction

	function automatic data_t mul_model(logic [2:0] f3, data_t a, data_t b);
		logic [63:0] ae;
		logic [63:0] be;
		logic [63:0] p;
		ae = (f3 == MULH || f3 == MULHSU) ? {{32{a[31]}}, a} : {32'b0, a};
		be = (f3 == MULH) ? {{32{b[31]}}, b} : {32'b0, b};
		p  = ae * be; // low 64 bits of the sign-extended product
		return (f3 == MUL) ? p[31:0] : p[63:32];
	endfunction

	function automatic data_t div_model(logic [2:0] f3, data_t a, data_t b);
		logic signed [31:0] sa;
		logic signed [31:0] sb;
		data_t              q;
		data_t              r;
		sa = a;
		sb = b;
		if (b == 32'h0) begin
			q = '1;
			r = a;
		end else if (f3 == DIV || f3 == REM) begin
			if (a == 32'h8000_0000 && b == 32'hFFFF_FFFF) begin
				q = a; // signed overflow
				r = 32'h0;
			end else begin
				q = data_t'(sa / sb);
				r = data_t'(sa % sb);
			end
		end else begin
			q = a / b;
			r = a % b;
		end
		return f3[1] ? r : q;
	endfunction

	function automatic data_t model_result(instr_t ins, data_t a, data_t b, data_t p);
		case (ins.opcode)
			R: begin
				if (ins.funct7 == M_INSTR)
					return ins.funct3[2] ? div_model(ins.funct3, a, b) :
					                       mul_model(ins.funct3, a, b);
				return base_model(ins, a, b);
			end
			I:                 return base_model(ins, a, b);
			LUI:               return get_imm(ins);
			AUIPC, JAL:        return p + get_imm(ins);
			JALR, LOAD, STORE: return a + get_imm(ins);
			default:           return 32'h0;
		endcase
	endfunction

	function automatic logic model_rd_wr(instr_t ins);
		case (ins.opcode)
			R, I, LUI, AUIPC, JAL, JALR, LOAD: return 1'b1;
			default:                           return 1'b0;
		endcase
	endfunction

	task automatic check_value(string what, data_t got, data_t exp);
		n_checks++;
		assert (got === exp) else begin
			value_errors++;
			$display("CHECK FAILED at %0d ns: %s: got %08h, expected %08h",
			         $time, what, got, exp);
		end
	endtask

	task automatic apply(instr_t ins, data_t a, data_t b, data_t p);
		@(negedge clk);
		instr    = ins;
		rs1_data = a;
		rs2_data = b;
		pc       = p;
	endtask

	task automatic run_single(instr_t ins, data_t a, data_t b, data_t p);
		string tag;
		tag = $sformatf("instr %08h rs1 %08h rs2 %08h pc %08h", ins, a, b, p);
		apply(ins, a, b, p);
		@(negedge clk);
		check_value({tag, " result"}, result, model_result(ins, a, b, p));
		check_value({tag, " rd_wr"}, data_t'(rd_wr), data_t'(model_rd_wr(ins)));
	endtask

	// hold the M instruction until its valid, then one idle cycle
	task automatic run_multi(instr_t ins, data_t a, data_t b);
		string tag;
		int    waited;
		int    limit;
		logic  seen;
		tag   = $sformatf("instr %08h rs1 %08h rs2 %08h", ins, a, b);
		limit = ins.funct3[2] ? DIV_LATENCY : MUL_LATENCY;
		apply(ins, a, b, rand32());
		waited = 0;
		seen   = 1'b0;
		while (!seen && waited < limit) begin
			@(negedge clk);
			waited++;
			seen = ins.funct3[2] ? div_valid : mul_valid;
		end
		n_checks++;
		assert (seen) else begin
			other_errors++;
			$display("ERROR at %0d ns: %s: valid did not rise within %0d cycles",
			         $time, tag, limit);
		end
		if (seen) begin
			check_value({tag, " result"}, result, model_result(ins, a, b, 32'h0));
			check_value({tag, " rd_wr"}, data_t'(rd_wr), 32'h1);
		end
		apply(instr_t'(32'h0), rand32(), rand32(), rand32()); // unknown opcode, no write
	endtask

	task automatic run_corners();
		for (int k = 0; k < 4; k++) begin
			run_multi(m_instr(3'(k)), 32'h8000_0000, 32'h8000_0000);
			run_multi(m_instr(3'(k)), 32'h7FFF_FFFF, 32'hFFFF_FFFF);
			run_multi(m_instr(3'(k)), 32'h0000_0000, 32'hFFFF_FFFF);
			run_multi(m_instr(3'(k + 4)), rand32(), 32'h0);     // divide by zero
			run_multi(m_instr(3'(k + 4)), 32'h8000_0000, 32'hFFFF_FFFF);
			run_multi(m_instr(3'(k + 4)), 32'h0000_0000, 32'h0000_0000);
		end
	endtask

	task automatic run_random_test();
		logic [31:0] sel;
		instr_t      ins;
		data_t       a;
		data_t       b;
		sel = rand32();
		ins = instr_t'(rand32());
		a   = pick_operand();
		b   = pick_operand();
		case (sel % 32'd6)
			32'd0, 32'd1: begin
				ins.opcode = sel[8] ? R : I;
				if (sel[8] || ins.funct3 == SLL || ins.funct3 == SRL)
					ins.funct7 = (sel[9] && (ins.funct3 == ADD || ins.funct3 == SRL)) ?
					             7'h20 : 7'h00;
				run_single(ins, a, b, rand32());
			end
			32'd2: begin
				case (sel[18:16] % 3'd6)
					3'd0:    ins.opcode = LUI;
					3'd1:    ins.opcode = AUIPC;
					3'd2:    ins.opcode = JAL;
					3'd3:    ins.opcode = JALR;
					3'd4:    ins.opcode = LOAD;
					default: ins.opcode = STORE;
				endcase
				run_single(ins, a, b, rand32());
			end
			32'd3: begin
				case (sel[11:10])
					2'd0:    ins.opcode = B;
					2'd1:    ins.opcode = MEM;
					2'd2:    ins.opcode = SYS;
					default: ins.opcode = 7'b1111111; // unused encoding
				endcase
				run_single(ins, a, b, rand32());
			end
			32'd4:   run_multi(m_instr({1'b0, sel[11:10]}), a, b);
			default: run_multi(m_instr({1'b1, sel[11:10]}), a, b);
		endcase
	endtask

	task automatic report_counts();
		$display("checks %0d, value errors %0d, other errors %0d",
		         n_checks, value_errors, other_errors);
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			report_counts();
			$display(">>> FAIL");
			$finish;
		end
	end

	initial begin
		rng_state = SEED;
		instr     = m_instr(MUL); // multiply held through reset
		rs1_data  = rand32();
		rs2_data  = rand32();
		pc        = '0;
		rst_n     = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_value("mul_valid after reset", data_t'(mul_valid), NULL);
		check_value("div_valid after reset", data_t'(div_valid), NULL);
		apply(instr_t'(32'h0), rand32(), rand32(), rand32()); // drain the reset multiply
		run_corners();
		for (int t = 0; t < N_TESTS; t++)
			run_random_test();
		report_counts();
		if (value_errors == 0 && other_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  logic             clk,   // multi-cycle units only
	input  logic             rst_n,
	input  rv32_pkg::instr_t instr,
	input  rv32_pkg::data_t  a_in,
	input  rv32_pkg::data_t  b_in,
	output rv32_pkg::data_t  c_out,
	output logic             rd_wr,
	output logic             div_result_valid,
	output logic             mul_result_valid
);
	import rv32_pkg::*;

	opcode_t     opcode;
	funct3_t     funct3;
	shift_type_t shift_type;
	logic [4:0]  shamt;
	logic        sub_func;
	data_t       imm;
	data_t       b_op;   // rs2 or immediate
	data_t       adder_in2;
	logic        set_signed_flag;
	logic        set_unsigned_flag;
	logic        set_flag;
	data_t       and_result;
	data_t       or_result;
	data_t       xor_result;
	data_t       set_result;
	data_t       shift_result;
	data_t       add_sub_result;
	data_t       arith_result;
	data_t       mult_result;
	data_t       div_rem_result;

	always_comb begin : field_decode
		opcode     = opcode_t'(instr.opcode);
		funct3     = funct3_t'(instr.funct3);
		shift_type = shift_type_t'(instr[30]);
		sub_func   = (opcode == R) & instr[30];
		imm        = get_imm(instr);
		b_op       = (opcode == I) ? imm : b_in;
		shamt      = (opcode == I) ? instr.rs2 : b_in[4:0];
	end

	always_comb begin : logic_ops
		and_result = a_in & b_op;
		or_result  = a_in | b_op;
		xor_result = a_in ^ b_op;
	end

	always_comb begin : shifter
		shift_result = NULL;
		case (funct3)
			SLL: shift_result = a_in << shamt;
			SRL: begin
				if (shift_type == arithmetic)
					shift_result = $signed(a_in) >>> shamt;
				else
					shift_result = a_in >> shamt;
			end
			default: shift_result = NULL;
		endcase
	end

	always_comb begin : add_sub
		adder_in2      = sub_func ? ~b_op : b_op;   // a - b = a + ~b + 1
		add_sub_result = a_in + adder_in2 + data_t'(sub_func);
	end

	always_comb begin : setter
		set_signed_flag   = ($signed(a_in) < $signed(b_op));
		set_unsigned_flag = (a_in < b_op);
		set_flag = (funct3 == SLT)  ? set_signed_flag :
		           (funct3 == SLTU) ? set_unsigned_flag : 1'b0;
		set_result = set_flag ? data_t'(1) : NULL;
	end

	// shared by register and immediate forms
	always_comb begin : arith_sel
		case (funct3)
			ADD:       arith_result = add_sub_result; // also SUB
			SLL, SRL:  arith_result = shift_result;   // SRL covers SRA
			SLT, SLTU: arith_result = set_result;
			XOR:       arith_result = xor_result;
			OR:        arith_result = or_result;
			AND:       arith_result = and_result;
			default:   arith_result = NULL;
		endcase
	end

	multiplier u_multiplier (
		.clk   (clk),
		.rst_n (rst_n),
		.instr (instr),
		.a_in  (a_in),
		.b_in  (b_in),
		.valid (mul_result_valid),
		.c_out (mult_result)
	);

	divider u_divider (
		.clk   (clk),
		.rst_n (rst_n),
		.instr (instr),
		.a_in  (a_in),
		.b_in  (b_in),
		.valid (div_result_valid),
		.c_out (div_rem_result)
	);

	always_comb begin : output_sel
		c_out = NULL;
		rd_wr = 1'b0;
		case (opcode)
			R: begin
				rd_wr = 1'b1;
				if (instr.funct7 == M_INSTR)
					c_out = instr.funct3[2] ? div_rem_result : mult_result;
				else
					c_out = arith_result;
			end
			I: begin
				rd_wr = 1'b1;
				c_out = arith_result;
			end
			LUI: begin
				rd_wr = 1'b1;
				c_out = b_in; // immediate already shifted up
			end
			AUIPC, JAL, JALR, LOAD: begin
				rd_wr = 1'b1;
				c_out = add_sub_result;
			end
			STORE: c_out = add_sub_result; // address only, nothing written back
			B, MEM, SYS: c_out = NULL;
			default: c_out = NULL;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/divider.sv
`timescale 1ns/1ps
`default_nettype none

module divider (
	input  logic             clk,
	input  logic             rst_n,
	input  rv32_pkg::instr_t instr,
	input  rv32_pkg::data_t  a_in,
	input  rv32_pkg::data_t  b_in,
	output logic             valid,
	output rv32_pkg::data_t  c_out
);
	import rv32_pkg::*;

	div_state_t                state;
	logic [$clog2(XLEN)-1:0]   count;
	mdiv_funct_t               op;
	logic                      is_div;
	logic                      signed_op;
	logic                      a_neg;
	logic                      b_neg;
	data_t                     a_mag;
	data_t                     b_mag;
	data_t                     dvs_q;     // divisor magnitude
	data_t                     quo_q;     // dividend shifts out, quotient shifts in
	data_t                     rem_q;
	logic                      q_neg_q;
	logic                      r_neg_q;
	logic                      rem_sel_q;
	logic [XLEN:0]             rem_shift;
	logic [XLEN:0]             diff;
	data_t                     quo_res;
	data_t                     rem_res;

	always_comb begin
		op        = mdiv_funct_t'(instr.funct3);
		is_div    = (instr.opcode == R) && (instr.funct7 == M_INSTR) && instr.funct3[2];
		signed_op = (op == DIV) || (op == REM);
		a_neg     = signed_op & a_in[XLEN-1];
		b_neg     = signed_op & b_in[XLEN-1];
		a_mag     = a_neg ? -a_in : a_in;
		b_mag     = b_neg ? -b_in : b_in;
		rem_shift = {rem_q, quo_q[XLEN-1]};
		diff      = rem_shift - {1'b0, dvs_q}; // msb set means the trial failed
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			count <= '0;
		end else begin
			case (state)
				IDLE: begin
					count <= '0;
					if (is_div)
						state <= RUN;
				end
				RUN: begin
					count <= count + 1'b1;
					if (&count) // last of XLEN steps
						state <= DONE;
				end
				DONE: begin
					if (!is_div)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && is_div) begin
			quo_q     <= a_mag;
			rem_q     <= NULL;
			dvs_q     <= b_mag;
			q_neg_q   <= (a_neg ^ b_neg) && (b_in != NULL); // x/0 stays all ones
			r_neg_q   <= a_neg;
			rem_sel_q <= (op == REM) || (op == REMU);
		end else if (state == RUN) begin
			rem_q <= diff[XLEN] ? rem_shift[XLEN-1:0] : diff[XLEN-1:0];
			quo_q <= {quo_q[XLEN-2:0], ~diff[XLEN]};
		end
	end

	// remainder takes the dividend's sign
	always_comb begin
		quo_res = q_neg_q ? -quo_q : quo_q;
		rem_res = r_neg_q ? -rem_q : rem_q;
	end

	assign valid = (state == DONE);
	assign c_out = rem_sel_q ? rem_res : quo_res;

endmodule

`default_nettype wire

// File: verilog/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
	input  logic             clk,
	input  logic             rst_n,
	input  rv32_pkg::instr_t instr,
	input  rv32_pkg::data_t  rs1_data,
	input  rv32_pkg::data_t  rs2_data,
	input  rv32_pkg::data_t  pc,
	output rv32_pkg::data_t  result,
	output logic             rd_wr,
	output logic             mul_valid,
	output logic             div_valid
);
	import rv32_pkg::*;

	opcode_t opcode;
	data_t   a_in;
	data_t   b_in;

	// operands arrive at the alu already resolved
	always_comb begin : operand_sel
		opcode = opcode_t'(instr.opcode);
		a_in   = (opcode == AUIPC || opcode == JAL) ? pc : rs1_data;
		case (opcode)
			LUI, AUIPC, JAL, JALR, LOAD, STORE: b_in = get_imm(instr);
			default:                            b_in = rs2_data;
		endcase
	end

	alu u_alu (
		.clk              (clk),
		.rst_n            (rst_n),
		.instr            (instr),
		.a_in             (a_in),
		.b_in             (b_in),
		.c_out            (result),
		.rd_wr            (rd_wr),
		.div_result_valid (div_valid),
		.mul_result_valid (mul_valid)
	);

endmodule

`default_nettype wire

// File: verilog/multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module multiplier (
	input  logic             clk,
	input  logic             rst_n,
	input  rv32_pkg::instr_t instr,
	input  rv32_pkg::data_t  a_in,
	input  rv32_pkg::data_t  b_in,
	output logic             valid,
	output rv32_pkg::data_t  c_out
);
	import rv32_pkg::*;

	mdiv_funct_t               op;
	mdiv_funct_t               op_q1;
	mdiv_funct_t               op_q2;
	logic                      is_mul;
	logic                      mul_q1;
	logic                      mul_q2;
	logic                      a_signed;
	logic                      b_signed;
	logic signed [XLEN:0]      a_q1; // one extra bit carries the signedness
	logic signed [XLEN:0]      b_q1;
	logic signed [2*XLEN+1:0]  prod_full;
	logic [2*XLEN-1:0]         prod_q2;

	always_comb begin
		op       = mdiv_funct_t'(instr.funct3);
		is_mul   = (instr.opcode == R) && (instr.funct7 == M_INSTR) && !instr.funct3[2];
		a_signed = (op == MULH) || (op == MULHSU);
		b_signed = (op == MULH);
		prod_full = a_q1 * b_q1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mul_q1 <= 1'b0;
			mul_q2 <= 1'b0;
		end else begin
			mul_q1 <= is_mul;
			mul_q2 <= mul_q1;
		end
	end

	always_ff @(posedge clk) begin
		a_q1    <= {a_signed & a_in[XLEN-1], a_in}; // stage one
		b_q1    <= {b_signed & b_in[XLEN-1], b_in};
		op_q1   <= op;
		prod_q2 <= prod_full[2*XLEN-1:0]; // stage two
		op_q2   <= op_q1;
	end

	assign valid = mul_q2;
	assign c_out = (op_q2 == MUL) ? prod_q2[XLEN-1:0] : prod_q2[2*XLEN-1:XLEN];

endmodule

`default_nettype wire

// File: verilog/rv32_pkg.sv
`default_nettype none

package rv32_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] data_t;

	// raw instruction word, fields in RV32 bit order
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} instr_t;

	typedef enum logic [6:0] {
		R     = 7'b0110011,
		I     = 7'b0010011,
		B     = 7'b1100011,
		LUI   = 7'b0110111,
		AUIPC = 7'b0010111,
		JAL   = 7'b1101111,
		JALR  = 7'b1100111,
		LOAD  = 7'b0000011,
		STORE = 7'b0100011,
		MEM   = 7'b0001111, // fence
		SYS   = 7'b1110011
	} opcode_t;

	// SUB and SRA reuse ADD and SRL, told apart by bit 30
	typedef enum logic [2:0] {
		ADD  = 3'b000,
		SLL  = 3'b001,
		SLT  = 3'b010,
		SLTU = 3'b011,
		XOR  = 3'b100,
		SRL  = 3'b101,
		OR   = 3'b110,
		AND  = 3'b111
	} funct3_t;

	typedef enum logic [2:0] {
		MUL    = 3'b000,
		MULH   = 3'b001,
		MULHSU = 3'b010,
		MULHU  = 3'b011,
		DIV    = 3'b100,
		DIVU   = 3'b101,
		REM    = 3'b110,
		REMU   = 3'b111
	} mdiv_funct_t;

	localparam logic [6:0] M_INSTR = 7'b0000001;
	localparam data_t      NULL    = '0;

	typedef enum logic {
		logical    = 1'b0,
		arithmetic = 1'b1
	} shift_type_t;

	typedef enum logic [1:0] {
		IDLE = 2'b00,
		RUN  = 2'b01,
		DONE = 2'b10
	} div_state_t;

	// sign-extended immediate, format picked by opcode
	function automatic data_t get_imm(instr_t instr);
		data_t imm;
		case (instr.opcode)
			I, JALR, LOAD: imm = {{20{instr[31]}}, instr[31:20]};
			STORE:         imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			B:             imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
			                      instr[11:8], 1'b0};
			LUI, AUIPC:    imm = {instr[31:12], 12'b0};
			JAL:           imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
			                      instr[30:21], 1'b0};
			default:       imm = NULL; // R, fence and system carry no immediate
		endcase
		return imm;
	endfunction

endpackage

`default_nettype wire
